// ==== include/disp_consts.svh ====
// ##############################
// Display controller constants
// ##############################

`ifndef DISP_CONSTS_SVH
`define DISP_CONSTS_SVH

// Number of seven-segment digits on the display
// Digit 0 is the units position and digit 7 the most significant
`define DISP_DIGITS 8

// Clock cycles that each digit stays lit during the scan
`define DISP_SCAN_DIV 16

// Width of the host register address
`define DISP_ADDR_W 4

// Address of the control register
// The digit registers occupy the addresses below it
`define DISP_CTRL_ADDR 8

`endif

// ==== src/disp_pkg.sv ====
// ##############################
// Display controller types
// ##############################

`default_nettype none

`include "disp_consts.svh"

package disp_pkg;

	// One BCD digit code
	// Codes 10 to 14 map to the odd TTL glyphs and 15 is blank
	typedef logic [3:0] bcd_t;

	// Segment pattern with a 1 for a lit segment
	// Bit 6 is segment a and bit 0 is segment g
	typedef logic [6:0] seg_t;

	// Control register layout as seen by the host
	// The first field lands in the most significant bit
	typedef struct packed {
		logic scan_enable;
		logic blank_all;
		logic zero_suppress;
		logic lamp_test;
	} ctrl_t;

	// Index of one digit position
	typedef logic [$clog2(`DISP_DIGITS)-1:0] idx_t;

	// One enable bit per digit, used for the scan outputs
	typedef logic [`DISP_DIGITS-1:0] en_t;

	// All digit codes, indexed by position
	typedef bcd_t [`DISP_DIGITS-1:0] digits_t;

	// All decoded patterns, indexed by position
	typedef seg_t [`DISP_DIGITS-1:0] patterns_t;

endpackage

`default_nettype wire

// ==== src/disp_cfg_if.sv ====
// ##############################
// Display config interface
// ##############################

`default_nettype none

// Carries the stored register state to the decoders and
// the decoded patterns on to the scanner
interface disp_cfg_if
	import disp_pkg::*;
();

	// Digit codes as written by the host
	digits_t digits;

	// Control bits as written by the host
	ctrl_t ctrl;

	// Segment patterns after the decoder bank
	// These are combinational from digits and ctrl
	patterns_t patterns;

	// Register block owns the stored state
	modport regs (
		output digits,
		output ctrl
	);

	// Decoder bank turns codes into patterns
	modport decode (
		input  digits,
		input  ctrl,
		output patterns
	);

	// Scanner only needs the patterns and the scan enable
	modport scan (
		input ctrl,
		input patterns
	);

endinterface

`default_nettype wire

// ==== src/disp_regs.sv ====
// ##############################
// Display register block
// ##############################

`default_nettype none

`include "disp_consts.svh"

module disp_regs
	import disp_pkg::*;
(
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    wr,
	input  wire logic [`DISP_ADDR_W-1:0] addr,
	input  wire logic [3:0]              wdata,
	output logic [3:0]                   rdata,
	disp_cfg_if.regs                     cfg
);

	// Stored digit codes and control bits
	digits_t digit_q;
	ctrl_t   ctrl_q;

	// Address decode results
	logic  digit_hit;
	logic  ctrl_hit;
	idx_t  idx;
	en_t   digit_sel;

	// An address below the digit count selects a digit register
	assign digit_hit = (addr < `DISP_DIGITS);
	assign ctrl_hit  = (addr == `DISP_CTRL_ADDR);
	assign idx       = idx_t'(addr);

	// One-hot digit select, all zero for any other address
	always_comb begin
		digit_sel = '0;
		if (digit_hit) begin
			digit_sel[idx] = 1'b1;
		end
	end

	// Host writes take effect on the strobe edge
	// Writes to unused addresses fall through without effect
	always_ff @(posedge clk) begin
		if (rst) begin
			digit_q <= '0;
			// Come out of reset scanning with leading zeros blanked
			ctrl_q  <= '{
				scan_enable:   1'b1,
				blank_all:     1'b0,
				zero_suppress: 1'b1,
				lamp_test:     1'b0
			};
		end else if (wr) begin
			for (int i = 0; i < `DISP_DIGITS; i++) begin
				if (digit_sel[i]) begin
					digit_q[i] <= wdata;
				end
			end
			if (ctrl_hit) begin
				ctrl_q <= ctrl_t'(wdata);
			end
		end
	end

	// Readback follows the address with no register stage
	// Unused addresses return zero
	always_comb begin
		rdata = '0;
		if (ctrl_hit) begin
			rdata = ctrl_q;
		end else begin
			for (int i = 0; i < `DISP_DIGITS; i++) begin
				if (digit_sel[i]) begin
					rdata = digit_q[i];
				end
			end
		end
	end

	// Stored state goes straight out to the decoders and scanner
	assign cfg.digits = digit_q;
	assign cfg.ctrl   = ctrl_q;

	// A write strobe selects at most one register
	a_single_target: assert property (
		@(posedge clk) disable iff (rst)
		wr |-> $onehot0({digit_sel, ctrl_hit})
	);

endmodule

`default_nettype wire

// ==== src/bcd_seg_decoder.sv ====
// ##############################
// BCD seven-segment decoder
// ##############################

`default_nettype none

module bcd_seg_decoder
	import disp_pkg::*;
(
	input  wire bcd_t code,
	input  wire logic lamp_test,
	input  wire logic blank,
	input  wire logic rb_in,
	output seg_t      pattern,
	output logic      rb_out
);

	// Raw glyph for the code before any blanking
	seg_t glyph;

	// Glyph table with segment a in bit 6 down to g in bit 0
	always_comb begin
		case (code)
			4'd0:    glyph = 7'b1111110;
			4'd1:    glyph = 7'b0110000;
			4'd2:    glyph = 7'b1101101;
			4'd3:    glyph = 7'b1111001;
			4'd4:    glyph = 7'b0110011;
			4'd5:    glyph = 7'b1011011;
			// Six and nine come without the extra tails
			4'd6:    glyph = 7'b0011111;
			4'd7:    glyph = 7'b1110000;
			4'd8:    glyph = 7'b1111111;
			4'd9:    glyph = 7'b1110011;
			// The TTL part shows odd fragments for 10 to 14
			4'd10:   glyph = 7'b0001101;
			4'd11:   glyph = 7'b0011001;
			4'd12:   glyph = 7'b0100011;
			4'd13:   glyph = 7'b1001011;
			4'd14:   glyph = 7'b0001111;
			default: glyph = 7'b0000000;
		endcase
	end

	// Priority order is blank, then lamp test, then ripple blank
	// Only a suppressed zero raises rb_out for the next digit down
	always_comb begin
		rb_out  = 1'b0;
		pattern = glyph;
		if (blank) begin
			pattern = '0;
		end else if (lamp_test) begin
			pattern = '1;
		end else if (rb_in && (code == 4'd0)) begin
			pattern = '0;
			rb_out  = 1'b1;
		end
	end

	// A raised rb_out means this digit was a suppressed zero and is dark
	a_rb_out_cause: assert final (
		!rb_out || (rb_in && (code == 4'd0) && (pattern == '0))
	);

endmodule

`default_nettype wire

// ==== src/seg_decoder_bank.sv ====
// ##############################
// Segment decoder bank
// ##############################

`default_nettype none

`include "disp_consts.svh"

module seg_decoder_bank
	import disp_pkg::*;
(
	disp_cfg_if.decode cfg
);

	// Ripple-blank signals per digit position
	en_t rb_in;
	en_t rb_out;

	// The chain runs from the top digit down toward the units
	// A zero only blanks while every digit above it is also blank
	for (genvar i = 0; i < `DISP_DIGITS; i++) begin : g_dec
		if (i == 0) begin : g_units
			// Units never blank so an all-zero value still shows 0
			assign rb_in[i] = 1'b0;
		end else if (i == `DISP_DIGITS - 1) begin : g_top
			// Top digit starts the chain when suppression is on
			assign rb_in[i] = cfg.ctrl.zero_suppress;
		end else begin : g_mid
			assign rb_in[i] = rb_out[i+1];
		end

		bcd_seg_decoder u_dec (
			.code      (cfg.digits[i]),
			.lamp_test (cfg.ctrl.lamp_test),
			.blank     (cfg.ctrl.blank_all),
			.rb_in     (rb_in[i]),
			.pattern   (cfg.patterns[i]),
			.rb_out    (rb_out[i])
		);
	end

endmodule

`default_nettype wire

// ==== src/digit_scanner.sv ====
// ##############################
// Digit scanner
// ##############################

`default_nettype none

`include "disp_consts.svh"

module digit_scanner
	import disp_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	disp_cfg_if.scan  cfg,
	output seg_t      seg,
	output en_t       digit_en
);

	localparam int PRE_W = $clog2(`DISP_SCAN_DIV);

	// Prescaler for the slot length and the current digit index
	logic [PRE_W-1:0] pre_cnt;
	idx_t             idx;
	logic             slot_start;

	// A new slot begins on the last prescaler count
	assign slot_start = (pre_cnt == PRE_W'(`DISP_SCAN_DIV - 1));

	// Counters hold at their reset values while scanning is off
	always_ff @(posedge clk) begin
		if (rst || !cfg.ctrl.scan_enable) begin
			pre_cnt <= '0;
			idx     <= idx_t'(`DISP_DIGITS - 1);
		end else begin
			pre_cnt <= slot_start ? '0 : pre_cnt + 1'b1;
			if (slot_start) begin
				// Step down through the digits, wrap from units back to the top
				if (idx == '0) begin
					idx <= idx_t'(`DISP_DIGITS - 1);
				end else begin
					idx <= idx - 1'b1;
				end
			end
		end
	end

	// Output registers load once per slot
	// The pattern is captured when the slot starts and held after that
	always_ff @(posedge clk) begin
		if (rst || !cfg.ctrl.scan_enable) begin
			digit_en <= '0;
			seg      <= '0;
		end else if (slot_start) begin
			digit_en <= en_t'(1) << idx;
			seg      <= cfg.patterns[idx];
		end
	end

	// At most one digit is driven at any time
	a_en_onehot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(digit_en)
	);

	// Turning scan off darkens the display on the next edge
	a_en_off: assert property (
		@(posedge clk) disable iff (rst)
		!cfg.ctrl.scan_enable |=> (digit_en == '0) && (seg == '0)
	);

endmodule

`default_nettype wire

// ==== src/display_top.sv ====
// ##############################
// Seven-segment display top
// ##############################

`default_nettype none

`include "disp_consts.svh"

module display_top
	import disp_pkg::*;
(
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    wr,
	input  wire logic [`DISP_ADDR_W-1:0] addr,
	input  wire logic [3:0]              wdata,
	output logic [3:0]                   rdata,
	output seg_t                         seg,
	output en_t                          digit_en
);

	// Shared configuration between the three blocks
	disp_cfg_if cfg ();

	// Host side register file
	disp_regs u_regs (
		.clk   (clk),
		.rst   (rst),
		.wr    (wr),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata),
		.cfg   (cfg.regs)
	);

	// Combinational decode of all digits with the ripple-blank chain
	seg_decoder_bank u_bank (
		.cfg (cfg.decode)
	);

	// Time multiplexing onto the shared segment lines
	digit_scanner u_scan (
		.clk      (clk),
		.rst      (rst),
		.cfg      (cfg.scan),
		.seg      (seg),
		.digit_en (digit_en)
	);

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
// ##############################
// Testbench clock and reset
// ##############################

`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	// Free running clock with a 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reset is seen high on the first four rising edges
	// It drops on a falling edge so it never moves with the sample point
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verification/display_tb.sv ====
// ##############################
// Display controller testbench
// ##############################

`default_nettype none

`include "disp_consts.svh"

module display_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 40 * `DISP_SCAN_DIV;
	localparam int FIXED = 10;
	localparam int ROWS = FIXED + 20;
	// Control bit positions
	localparam int LT = 0;
	localparam int ZS = 1;
	localparam int BA = 2;

	logic clk;
	logic rst;
	logic wr;
	logic [`DISP_ADDR_W-1:0] addr;
	logic [3:0] wdata;
	logic [3:0] rdata;
	logic [6:0] seg;
	logic [`DISP_DIGITS-1:0] digit_en;

	// Stimulus table with digit 0 in the low nibble of each row
	logic [31:0] tab_digits [ROWS];
	logic [3:0]  tab_ctrl [ROWS];
	logic        tab_scan [ROWS];
	integer      seed;

	tb_clock u_clock (.clk(clk), .rst(rst));

	display_top DUT (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.addr     (addr),
		.wdata    (wdata),
		.rdata    (rdata),
		.seg      (seg),
		.digit_en (digit_en)
	);

	// Drive and sample point sits 1 ns after each rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out after %0d cycles while waiting for %s", TIMEOUT, what);
		$display("TESTS FAILED");
		$fatal(1, "wait timeout");
	endtask

	// Turns a list of segment letters into a pattern, a in bit 6 down to g in bit 0
	function automatic logic [6:0] seg_of(input string s);
		logic [6:0] p;
		p = '0;
		for (int k = 0; k < s.len(); k++) begin
			p[6 - (s[k] - "a")] = 1'b1;
		end
		return p;
	endfunction

	function automatic logic [6:0] glyph_ref(input logic [3:0] code);
		case (code)
			4'd0:    return seg_of("abcdef");
			4'd1:    return seg_of("bc");
			4'd2:    return seg_of("abdeg");
			4'd3:    return seg_of("abcdg");
			4'd4:    return seg_of("bcfg");
			4'd5:    return seg_of("acdfg");
			4'd6:    return seg_of("cdefg");
			4'd7:    return seg_of("abc");
			4'd8:    return seg_of("abcdefg");
			4'd9:    return seg_of("abcfg");
			4'd10:   return seg_of("deg");
			4'd11:   return seg_of("cdg");
			4'd12:   return seg_of("bfg");
			4'd13:   return seg_of("adfg");
			4'd14:   return seg_of("defg");
			default: return 7'b0;
		endcase
	endfunction

	// Walks the blanking chain from the top digit down to the wanted position
	function automatic logic [6:0] expected_seg(input logic [31:0] digs, input logic [3:0] ctrl,
			input int pos);
		logic       rb;
		logic [3:0] code;
		logic [6:0] pat;
		rb = ctrl[ZS];
		pat = '0;
		for (int i = `DISP_DIGITS - 1; i >= pos; i--) begin
			code = digs[4*i +: 4];
			// The units digit never blanks
			if (i == 0) rb = 1'b0;
			if (ctrl[BA]) begin
				pat = '0;
				rb = 1'b0;
			end else if (ctrl[LT]) begin
				pat = '1;
				rb = 1'b0;
			end else if (rb && code == 4'd0) begin
				pat = '0;
			end else begin
				pat = glyph_ref(code);
				rb = 1'b0;
			end
		end
		return pat;
	endfunction

	function automatic logic [3:0] read_ref(input int a, input logic [31:0] digs,
			input logic [3:0] ctrl);
		if (a < `DISP_DIGITS) return digs[4*a +: 4];
		if (a == `DISP_CTRL_ADDR) return ctrl;
		return 4'd0;
	endfunction

	task automatic write_reg(input int a, input logic [3:0] d);
		addr = a;
		wdata = d;
		wr = 1'b1;
		step();
		wr = 1'b0;
	endtask

	// Reads every address and compares with the stored state
	task automatic read_all(input logic [31:0] digs, input logic [3:0] ctrl, input int r);
		for (int a = 0; a < 2 ** `DISP_ADDR_W; a++) begin
			addr = a;
			step();
			check_value(rdata, read_ref(a, digs, ctrl),
				$sformatf("row %0d readback of %0d", r, a));
		end
	endtask

	// Leaves the slot if it already shows, then waits for its next start
	// A prev of -1 turns off the order check
	task automatic wait_slot(input int idx, input int prev, input string what);
		logic [`DISP_DIGITS-1:0] target;
		int n;
		target = '0;
		target[idx] = 1'b1;
		n = 0;
		while (digit_en === target) begin
			step();
			n++;
			if (n > TIMEOUT) timeout_fail($sformatf("%s to end", what));
		end
		n = 0;
		while (digit_en !== target) begin
			check_value($onehot0(digit_en), 1, "digit_en is not one-hot");
			if (prev >= 0) check_value(digit_en, 1 << prev, $sformatf("scan order at %s", what));
			step();
			n++;
			if (n > TIMEOUT) timeout_fail(what);
		end
	endtask

	// Once dark, the display has to stay dark for at least one whole scan
	task automatic wait_dark(input int r);
		int n;
		n = 0;
		while (digit_en !== '0 || seg !== '0) begin
			step();
			n++;
			if (n > TIMEOUT) timeout_fail($sformatf("display to go dark in row %0d", r));
		end
		for (int k = 0; k < `DISP_DIGITS * `DISP_SCAN_DIV; k++) begin
			step();
			check_value(digit_en, 0, $sformatf("row %0d digit_en with scan off", r));
			check_value(seg, 0, $sformatf("row %0d seg with scan off", r));
		end
	endtask

	task automatic fill_table();
		integer v;
		logic [31:0] d;
		// Digits, control and scan flag for the fixed rows
		tab_digits[0] = 32'h7654_3210;
		tab_ctrl[0] = 4'h8;
		tab_digits[1] = 32'hFEDC_BA98;
		tab_ctrl[1] = 4'h8;
		tab_digits[2] = 32'h0001_2034;
		tab_ctrl[2] = 4'hA;
		tab_digits[3] = 32'h0000_0000;
		tab_ctrl[3] = 4'hA;
		tab_digits[4] = 32'h0001_2034;
		tab_ctrl[4] = 4'h8;
		tab_digits[5] = 32'h0000_0500;
		tab_ctrl[5] = 4'hB;
		tab_digits[6] = 32'h1234_5678;
		tab_ctrl[6] = 4'hC;
		tab_digits[7] = 32'h0000_0000;
		tab_ctrl[7] = 4'hD;
		tab_digits[8] = 32'h1000_0000;
		tab_ctrl[8] = 4'hA;
		tab_digits[9] = 32'h0098_0700;
		tab_ctrl[9] = 4'h2;
		for (int r = 0; r < FIXED; r++) tab_scan[r] = tab_ctrl[r][3];
		// Random rows lean toward zeros so the blanking chain gets exercised
		for (int r = FIXED; r < ROWS; r++) begin
			for (int i = 0; i < `DISP_DIGITS; i++) begin
				v = $random(seed);
				d[4*i +: 4] = v[4] ? 4'd0 : v[3:0];
			end
			v = $random(seed);
			tab_digits[r] = d;
			tab_ctrl[r] = {1'b1, v[2] & v[5], v[1], v[0] & v[6]};
			tab_scan[r] = 1'b1;
		end
	endtask

	task automatic apply_row(input int r);
		for (int i = 0; i < `DISP_DIGITS; i++) write_reg(i, tab_digits[r][4*i +: 4]);
		write_reg(`DISP_CTRL_ADDR, tab_ctrl[r]);
		read_all(tab_digits[r], tab_ctrl[r], r);
		if (tab_scan[r]) begin
			// Two starts of the top slot make sure a whole scan holds the new data
			wait_slot(`DISP_DIGITS - 1, -1, $sformatf("first top slot in row %0d", r));
			wait_slot(`DISP_DIGITS - 1, -1, $sformatf("second top slot in row %0d", r));
			for (int p = `DISP_DIGITS - 1; p >= 0; p--) begin
				if (p < `DISP_DIGITS - 1) begin
					wait_slot(p, p + 1, $sformatf("slot %0d in row %0d", p, r));
				end
				check_value(seg, expected_seg(tab_digits[r], tab_ctrl[r], p),
					$sformatf("row %0d slot %0d seg", r, p));
			end
		end else begin
			wait_dark(r);
		end
	endtask

	initial begin
		int n;
		seed = 11928;
		wr = 1'b0;
		addr = '0;
		wdata = '0;
		fill_table();
		n = 0;
		step();
		while (rst) begin
			step();
			n++;
			if (n > TIMEOUT) timeout_fail("reset release");
		end
		// Reset state has zero digits and scanning with zero suppression
		read_all(32'h0, 4'hA, -1);
		for (int r = 0; r < ROWS; r++) apply_row(r);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
src/disp_pkg.sv
src/disp_cfg_if.sv
src/disp_regs.sv
src/bcd_seg_decoder.sv
src/seg_decoder_bank.sv
src/digit_scanner.sv
src/display_top.sv
verification/tb_clock.sv
verification/display_tb.sv

// ==== Bender.yml ====
package:
  name: seven_seg_display

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/disp_pkg.sv
      - src/disp_cfg_if.sv
      - src/disp_regs.sv
      - src/bcd_seg_decoder.sv
      - src/seg_decoder_bank.sv
      - src/digit_scanner.sv
      - src/display_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/tb_clock.sv
      - verification/display_tb.sv
